/* rtl/dispatch_consts.svh */
`ifndef DISPATCH_CONSTS_SVH
`define DISPATCH_CONSTS_SVH

// threads carried by one warp instruction
`define DSP_NUM_THREADS 8

// lanes per packet, so one packet holds a quarter of the warp
`define DSP_NUM_LANES 2
`define DSP_NUM_PACKETS (`DSP_NUM_THREADS / `DSP_NUM_LANES)
`define DSP_PID_W 2

`define DSP_XLEN 32
`define DSP_UUID_W 8
`define DSP_WID_W 4

// two entries let the buffer stream at full rate
`define DSP_BUF_DEPTH 2

`endif

/* rtl/dispatch_pkg.sv */
`include "dispatch_consts.svh"

package dispatch_pkg;

    // operation applied by the lane ALU to rs1 and rs2
    typedef enum logic [1:0] {
        ADD = 2'd0,
        SUB = 2'd1,
        AND = 2'd2,
        XOR = 2'd3
    } alu_op_t;

    // one group of lanes cut out of a warp instruction
    typedef struct packed {
        logic [`DSP_UUID_W-1:0]                       uuid;
        logic [`DSP_WID_W-1:0]                        wid;
        alu_op_t                                      op;
        logic [`DSP_NUM_LANES-1:0]                    tmask;
        logic [`DSP_NUM_LANES-1:0][`DSP_XLEN-1:0]     rs1;
        logic [`DSP_NUM_LANES-1:0][`DSP_XLEN-1:0]     rs2;
        logic [`DSP_PID_W-1:0]                        pid;
        logic                                         sop;
        logic                                         eop;
    } lane_packet_t;

    // result of one lane packet, tags copied from the packet
    typedef struct packed {
        logic [`DSP_UUID_W-1:0]                       uuid;
        logic [`DSP_WID_W-1:0]                        wid;
        logic [`DSP_NUM_LANES-1:0]                    tmask;
        logic [`DSP_NUM_LANES-1:0][`DSP_XLEN-1:0]     data;
        logic [`DSP_PID_W-1:0]                        pid;
        logic                                         sop;
        logic                                         eop;
    } lane_result_t;

endpackage

/* rtl/elastic_buffer.sv */
`timescale 1ns/1ps
`include "dispatch_consts.svh"

module elastic_buffer #(
    parameter int  DEPTH  = `DSP_BUF_DEPTH,
    parameter type data_t = logic [7:0]
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  in_valid,
    output logic  in_ready,
    input  data_t in_data,
    output logic  out_valid,
    input  logic  out_ready,
    output data_t out_data
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    data_t            mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    // the head entry is a storage register, so a write shows up one edge later
    assign out_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

/* rtl/packet_splitter.sv */
`timescale 1ns/1ps
`include "dispatch_consts.svh"

module packet_splitter (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        issue_valid,
    output logic                                        issue_ready,
    input  logic [`DSP_UUID_W-1:0]                      issue_uuid,
    input  logic [`DSP_WID_W-1:0]                       issue_wid,
    input  dispatch_pkg::alu_op_t                       issue_op,
    input  logic [`DSP_NUM_THREADS-1:0]                 issue_tmask,
    input  logic [`DSP_NUM_THREADS-1:0][`DSP_XLEN-1:0]  issue_rs1,
    input  logic [`DSP_NUM_THREADS-1:0][`DSP_XLEN-1:0]  issue_rs2,
    output logic                                        pkt_valid,
    input  logic                                        pkt_ready,
    output dispatch_pkg::lane_packet_t                  pkt
);
    logic [`DSP_NUM_PACKETS-1:0][`DSP_NUM_LANES-1:0]                 grp_tmask;
    logic [`DSP_NUM_PACKETS-1:0][`DSP_NUM_LANES-1:0][`DSP_XLEN-1:0]  grp_rs1;
    logic [`DSP_NUM_PACKETS-1:0][`DSP_NUM_LANES-1:0][`DSP_XLEN-1:0]  grp_rs2;
    logic [`DSP_NUM_PACKETS-1:0]                                     grp_active;
    logic [`DSP_NUM_PACKETS-1:0]                                     sent_mask;
    logic                                                            is_first;
    logic [`DSP_PID_W-1:0]                                           start_pid;
    logic [`DSP_PID_W-1:0]                                           end_pid;
    logic                                                            is_last;
    logic                                                            fire;
    logic                                                            fire_eop;

    for (genvar g = 0; g < `DSP_NUM_PACKETS; g++) begin : g_group
        assign grp_tmask[g]  = issue_tmask[g*`DSP_NUM_LANES +: `DSP_NUM_LANES];
        assign grp_rs1[g]    = issue_rs1[g*`DSP_NUM_LANES +: `DSP_NUM_LANES];
        assign grp_rs2[g]    = issue_rs2[g*`DSP_NUM_LANES +: `DSP_NUM_LANES];
        assign grp_active[g] = |grp_tmask[g];
    end

    // scanning downwards leaves the lowest unsent group
    always_comb begin
        start_pid = '0;
        for (int i = `DSP_NUM_PACKETS - 1; i >= 0; i--) begin
            if (grp_active[i] && !sent_mask[i]) begin
                start_pid = `DSP_PID_W'(i);
            end
        end
    end

    always_comb begin
        end_pid = '0;
        for (int i = 0; i < `DSP_NUM_PACKETS; i++) begin
            if (grp_active[i]) begin
                end_pid = `DSP_PID_W'(i);
            end
        end
    end

    // an empty mask falls back to pid 0 on both scans, giving a single packet
    assign is_last  = (start_pid == end_pid);
    assign fire     = pkt_valid && pkt_ready;
    assign fire_eop = fire && is_last;

    assign pkt_valid   = issue_valid;
    assign issue_ready = fire_eop;

    always_comb begin
        pkt.uuid  = issue_uuid;
        pkt.wid   = issue_wid;
        pkt.op    = issue_op;
        pkt.tmask = grp_tmask[start_pid];
        pkt.rs1   = grp_rs1[start_pid];
        pkt.rs2   = grp_rs2[start_pid];
        pkt.pid   = start_pid;
        pkt.sop   = is_first;
        pkt.eop   = is_last;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sent_mask <= '0;
            is_first  <= 1'b1;
        end else if (fire_eop) begin
            // instruction consumed, rearm for the next one
            sent_mask <= '0;
            is_first  <= 1'b1;
        end else if (fire) begin
            sent_mask[start_pid] <= 1'b1;
            is_first             <= 1'b0;
        end
    end

endmodule

/* rtl/lane_alu.sv */
`timescale 1ns/1ps
`include "dispatch_consts.svh"

module lane_alu (
    input  logic                        pkt_valid,
    output logic                        pkt_ready,
    input  dispatch_pkg::lane_packet_t  pkt,
    output logic                        res_valid,
    input  logic                        res_ready,
    output dispatch_pkg::lane_result_t  res
);
    logic [`DSP_NUM_LANES-1:0][`DSP_XLEN-1:0] lane_data;

    // purely combinational, so the handshake passes straight through
    assign res_valid = pkt_valid;
    assign pkt_ready = res_ready;

    always_comb begin
        for (int j = 0; j < `DSP_NUM_LANES; j++) begin
            lane_data[j] = '0;
            if (pkt.tmask[j]) begin
                case (pkt.op)
                    dispatch_pkg::ADD: begin
                        lane_data[j] = pkt.rs1[j] + pkt.rs2[j];
                    end
                    dispatch_pkg::SUB: begin
                        lane_data[j] = pkt.rs1[j] - pkt.rs2[j];
                    end
                    dispatch_pkg::AND: begin
                        lane_data[j] = pkt.rs1[j] & pkt.rs2[j];
                    end
                    dispatch_pkg::XOR: begin
                        lane_data[j] = pkt.rs1[j] ^ pkt.rs2[j];
                    end
                    default: begin
                        lane_data[j] = '0;
                    end
                endcase
            end
        end
    end

    // masked lanes already read zero from lane_data
    always_comb begin
        res.uuid  = pkt.uuid;
        res.wid   = pkt.wid;
        res.tmask = pkt.tmask;
        res.data  = lane_data;
        res.pid   = pkt.pid;
        res.sop   = pkt.sop;
        res.eop   = pkt.eop;
    end

endmodule

/* rtl/dispatch_top.sv */
`timescale 1ns/1ps
`include "dispatch_consts.svh"

module dispatch_top (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        issue_valid,
    output logic                                        issue_ready,
    input  logic [`DSP_UUID_W-1:0]                      issue_uuid,
    input  logic [`DSP_WID_W-1:0]                       issue_wid,
    input  dispatch_pkg::alu_op_t                       issue_op,
    input  logic [`DSP_NUM_THREADS-1:0]                 issue_tmask,
    input  logic [`DSP_NUM_THREADS-1:0][`DSP_XLEN-1:0]  issue_rs1,
    input  logic [`DSP_NUM_THREADS-1:0][`DSP_XLEN-1:0]  issue_rs2,
    output logic                                        res_valid,
    input  logic                                        res_ready,
    output logic [`DSP_UUID_W-1:0]                      res_uuid,
    output logic [`DSP_WID_W-1:0]                       res_wid,
    output logic [`DSP_NUM_LANES-1:0]                   res_tmask,
    output logic [`DSP_NUM_LANES-1:0][`DSP_XLEN-1:0]    res_data,
    output logic [`DSP_PID_W-1:0]                       res_pid,
    output logic                                        res_sop,
    output logic                                        res_eop
);
    logic                        split_valid;
    logic                        split_ready;
    dispatch_pkg::lane_packet_t  split_pkt;
    logic                        alu_pkt_valid;
    logic                        alu_pkt_ready;
    dispatch_pkg::lane_packet_t  alu_pkt;
    logic                        alu_res_valid;
    logic                        alu_res_ready;
    dispatch_pkg::lane_result_t  alu_res;
    dispatch_pkg::lane_result_t  out_res;

    packet_splitter splitter (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue_uuid  (issue_uuid),
        .issue_wid   (issue_wid),
        .issue_op    (issue_op),
        .issue_tmask (issue_tmask),
        .issue_rs1   (issue_rs1),
        .issue_rs2   (issue_rs2),
        .pkt_valid   (split_valid),
        .pkt_ready   (split_ready),
        .pkt         (split_pkt)
    );

    elastic_buffer #(
        .DEPTH  (`DSP_BUF_DEPTH),
        .data_t (dispatch_pkg::lane_packet_t)
    ) pkt_buf (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (split_valid),
        .in_ready  (split_ready),
        .in_data   (split_pkt),
        .out_valid (alu_pkt_valid),
        .out_ready (alu_pkt_ready),
        .out_data  (alu_pkt)
    );

    lane_alu alu (
        .pkt_valid (alu_pkt_valid),
        .pkt_ready (alu_pkt_ready),
        .pkt       (alu_pkt),
        .res_valid (alu_res_valid),
        .res_ready (alu_res_ready),
        .res       (alu_res)
    );

    // registers results on their way out
    elastic_buffer #(
        .DEPTH  (`DSP_BUF_DEPTH),
        .data_t (dispatch_pkg::lane_result_t)
    ) res_buf (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (alu_res_valid),
        .in_ready  (alu_res_ready),
        .in_data   (alu_res),
        .out_valid (res_valid),
        .out_ready (res_ready),
        .out_data  (out_res)
    );

    assign res_uuid  = out_res.uuid;
    assign res_wid   = out_res.wid;
    assign res_tmask = out_res.tmask;
    assign res_data  = out_res.data;
    assign res_pid   = out_res.pid;
    assign res_sop   = out_res.sop;
    assign res_eop   = out_res.eop;

endmodule

/* test/dispatch_checker.sv */
`timescale 1ns/1ps
`include "dispatch_consts.svh"

module dispatch_checker (
    input logic                         clk,
    input logic                         reset,
    input logic                         issue_ready,
    input logic [`DSP_NUM_THREADS-1:0]  issue_tmask,
    input logic                         pkt_valid,
    input logic                         pkt_ready,
    input dispatch_pkg::lane_packet_t   pkt
);
    int fail_count = 0;

    // the instruction is consumed only with the packet of its highest active group
    ack_on_eop: assert property (@(posedge clk) disable iff (reset)
        issue_ready |-> (pkt_valid && pkt_ready && pkt.eop
            && ((issue_tmask >> (`DSP_NUM_LANES * (int'(pkt.pid) + 1))) == '0)))
    else begin
        $error("issue_ready high without a transfer of the highest active packet");
        fail_count++;
    end

    hold_while_stalled: assert property (@(posedge clk) disable iff (reset)
        (pkt_valid && !pkt_ready) |=> (pkt_valid && $stable(pkt)))
    else begin
        $error("packet changed or dropped while stalled");
        fail_count++;
    end

    quiet_in_reset: assert property (@(posedge clk)
        reset |-> (!issue_ready && !pkt_valid))
    else begin
        $error("splitter handshake active during reset");
        fail_count++;
    end

endmodule

bind packet_splitter dispatch_checker handshake_check (
    .clk         (clk),
    .reset       (reset),
    .issue_ready (issue_ready),
    .issue_tmask (issue_tmask),
    .pkt_valid   (pkt_valid),
    .pkt_ready   (pkt_ready),
    .pkt         (pkt)
);

/* test/dispatch_tb.sv */
`timescale 1ns/1ps
`include "dispatch_consts.svh"

module dispatch_tb;
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_INSTR    = 60;
    localparam int MAX_CYCLES   = RESET_CYCLES + NUM_INSTR * `DSP_NUM_PACKETS * 10;
    localparam int L            = `DSP_NUM_LANES;

    logic                                        clk = 1'b0;
    logic                                        reset;
    logic                                        issue_valid;
    logic                                        issue_ready;
    logic [`DSP_UUID_W-1:0]                      issue_uuid;
    logic [`DSP_WID_W-1:0]                       issue_wid;
    dispatch_pkg::alu_op_t                       issue_op;
    logic [`DSP_NUM_THREADS-1:0]                 issue_tmask;
    logic [`DSP_NUM_THREADS-1:0][`DSP_XLEN-1:0]  issue_rs1;
    logic [`DSP_NUM_THREADS-1:0][`DSP_XLEN-1:0]  issue_rs2;
    logic                                        res_valid;
    logic                                        res_ready = 1'b0;
    logic [`DSP_UUID_W-1:0]                      res_uuid;
    logic [`DSP_WID_W-1:0]                       res_wid;
    logic [`DSP_NUM_LANES-1:0]                   res_tmask;
    logic [`DSP_NUM_LANES-1:0][`DSP_XLEN-1:0]    res_data;
    logic [`DSP_PID_W-1:0]                       res_pid;
    logic                                        res_sop;
    logic                                        res_eop;

    dispatch_pkg::lane_result_t exp_q [$];
    dispatch_pkg::lane_result_t exp_r;
    integer                     seed = 45;
    integer                     ready_seed = 45;
    logic [31:0]                ready_roll;
    logic                       stim_started = 1'b0;
    logic                       pending = 1'b0;
    int                         errors = 0;
    int                         acks = 0;
    int                         results = 0;
    int                         queued = 0;
    int                         pkt_count = 0;
    int                         valid_cycles = 0;

    dispatch_top dispatch_top_inst (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // res_ready drops for roughly one cycle in three
    always @(posedge clk) begin
        ready_roll = $random(ready_seed);
        if (reset) begin
            res_ready <= 1'b0;
        end else begin
            res_ready <= (ready_roll % 3) != 0;
        end
    end

    // expected result of group g, or of group 0 when the mask is empty
    function automatic dispatch_pkg::lane_result_t expected_result(
        input logic [`DSP_UUID_W-1:0]                      uuid,
        input logic [`DSP_WID_W-1:0]                       wid,
        input dispatch_pkg::alu_op_t                       op,
        input logic [`DSP_NUM_THREADS-1:0]                 tmask,
        input logic [`DSP_NUM_THREADS-1:0][`DSP_XLEN-1:0]  rs1,
        input logic [`DSP_NUM_THREADS-1:0][`DSP_XLEN-1:0]  rs2,
        input int                                          g
    );
        dispatch_pkg::lane_result_t r;
        int                         first_g;
        int                         last_g;
        int                         t;
        first_g = -1;
        last_g  = 0;
        for (int k = 0; k < `DSP_NUM_PACKETS; k++) begin
            if (|tmask[k*L +: L]) begin
                if (first_g < 0) begin
                    first_g = k;
                end
                last_g = k;
            end
        end
        if (first_g < 0) begin
            first_g = 0;
        end
        r.uuid = uuid;
        r.wid  = wid;
        r.pid  = `DSP_PID_W'(g);
        r.sop  = (g == first_g);
        r.eop  = (g == last_g);
        for (int j = 0; j < L; j++) begin
            t = g * L + j;
            r.tmask[j] = tmask[t];
            r.data[j]  = '0;
            if (tmask[t]) begin
                case (op)
                    dispatch_pkg::ADD: r.data[j] = rs1[t] + rs2[t];
                    dispatch_pkg::SUB: r.data[j] = rs1[t] - rs2[t];
                    dispatch_pkg::AND: r.data[j] = rs1[t] & rs2[t];
                    default:           r.data[j] = rs1[t] ^ rs2[t];
                endcase
            end
        end
        return r;
    endfunction

    task automatic push_expected();
        for (int g = 0; g < `DSP_NUM_PACKETS; g++) begin
            if ((|issue_tmask[g*L +: L]) || (issue_tmask == '0 && g == 0)) begin
                exp_q.push_back(expected_result(issue_uuid, issue_wid, issue_op,
                                                issue_tmask, issue_rs1, issue_rs2, g));
            end
        end
    endtask

    task automatic drive_instruction(input int n);
        logic [31:0]                                 rnd;
        logic [`DSP_NUM_THREADS-1:0]                 mask;
        logic [`DSP_NUM_THREADS-1:0][`DSP_XLEN-1:0]  rs1;
        logic [`DSP_NUM_THREADS-1:0][`DSP_XLEN-1:0]  rs2;
        rnd = $random(seed);
        case (n)
            0: mask = '1;
            1: mask = '0;
            2: mask = 8'h0c;
            3: mask = 8'h41;
            4: mask = 8'hc0;
            5: mask = 8'h24;
            default: begin
                mask = rnd[`DSP_NUM_THREADS-1:0];
                if (n % 8 == 0) begin
                    mask = '0;
                end else if (n % 8 == 3) begin
                    mask = mask & 8'h33;
                end
            end
        endcase
        for (int t = 0; t < `DSP_NUM_THREADS; t++) begin
            rs1[t] = $random(seed);
            rs2[t] = $random(seed);
        end
        rnd = $random(seed);
        issue_valid <= 1'b1;
        issue_uuid  <= n[`DSP_UUID_W-1:0];
        issue_wid   <= rnd[`DSP_WID_W-1:0];
        issue_op    <= dispatch_pkg::alu_op_t'((n < 8) ? n[1:0] : rnd[5:4]);
        issue_tmask <= mask;
        issue_rs1   <= rs1;
        issue_rs2   <= rs2;
    endtask

    // outputs are sampled on the falling edge, half a cycle ahead of the transfer edge
    always @(negedge clk) begin
        if (!stim_started) begin
            if (res_valid !== 1'b0) begin
                $display("Error: time %0t res_valid expected 0 actual %b", $time, res_valid);
                errors++;
            end
            if (issue_ready !== 1'b0) begin
                $display("Error: time %0t issue_ready expected 0 actual %b", $time, issue_ready);
                errors++;
            end
        end
        if (!reset) begin
            if (issue_valid && !pending) begin
                queued = exp_q.size();
                push_expected();
                pkt_count    = exp_q.size() - queued;
                valid_cycles = 0;
                pending      = 1'b1;
            end
            if (issue_valid) begin
                valid_cycles++;
            end
            // one packet leaves per cycle, so the end packet cannot come sooner
            if (issue_valid && issue_ready) begin
                if (valid_cycles < pkt_count) begin
                    $display("at time %0t instruction %0h was acknowledged after %0d cycles",
                             $time, issue_uuid, valid_cycles);
                    $display("with %0d packets to send", pkt_count);
                    errors++;
                end
                pending = 1'b0;
                acks++;
            end
            if (res_valid && res_ready) begin
                if (exp_q.size() == 0) begin
                    $display("at time %0t a result came out with none expected", $time);
                    errors++;
                end else begin
                    exp_r = exp_q.pop_front();
                    results++;
                    if (res_uuid !== exp_r.uuid) begin
                        $display("Error: time %0t res_uuid expected %h actual %h",
                                 $time, exp_r.uuid, res_uuid);
                        errors++;
                    end
                    if (res_wid !== exp_r.wid) begin
                        $display("Error: time %0t res_wid expected %h actual %h",
                                 $time, exp_r.wid, res_wid);
                        errors++;
                    end
                    if (res_tmask !== exp_r.tmask) begin
                        $display("Error: time %0t res_tmask expected %b actual %b",
                                 $time, exp_r.tmask, res_tmask);
                        errors++;
                    end
                    if (res_data !== exp_r.data) begin
                        $display("Error: time %0t res_data expected %h actual %h",
                                 $time, exp_r.data, res_data);
                        errors++;
                    end
                    if (res_pid !== exp_r.pid) begin
                        $display("Error: time %0t res_pid expected %0d actual %0d",
                                 $time, exp_r.pid, res_pid);
                        errors++;
                    end
                    if (res_sop !== exp_r.sop) begin
                        $display("Error: time %0t res_sop expected %b actual %b",
                                 $time, exp_r.sop, res_sop);
                        errors++;
                    end
                    if (res_eop !== exp_r.eop) begin
                        $display("Error: time %0t res_eop expected %b actual %b",
                                 $time, exp_r.eop, res_eop);
                        errors++;
                    end
                end
            end
        end
    end

    initial begin
        int total;
        reset       <= 1'b1;
        issue_valid <= 1'b0;
        issue_uuid  <= '0;
        issue_wid   <= '0;
        issue_op    <= dispatch_pkg::ADD;
        issue_tmask <= '0;
        issue_rs1   <= '0;
        issue_rs2   <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        repeat (4) @(posedge clk);
        for (int n = 0; n < NUM_INSTR; n++) begin
            stim_started = 1'b1;
            drive_instruction(n);
            @(negedge clk);
            while (issue_ready !== 1'b1) begin
                @(negedge clk);
            end
            @(posedge clk);
            if (($random(seed) & 3) == 0) begin
                issue_valid <= 1'b0;
                @(posedge clk);
            end
        end
        issue_valid <= 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(posedge clk);
        total = errors + dispatch_top_inst.splitter.handshake_check.fail_count;
        $display("summary: %0d errors, %0d results checked, %0d instructions acknowledged",
                 total, results, acks);
        if (total == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #(MAX_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* compile.f */
+incdir+rtl
rtl/dispatch_pkg.sv
rtl/elastic_buffer.sv
rtl/packet_splitter.sv
rtl/lane_alu.sv
rtl/dispatch_top.sv
test/dispatch_checker.sv
test/dispatch_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := dispatch_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
LOG       := sim.log
SIM_FLAGS := +verilator+error+limit+100
FAIL_MSG  := FAIL: see errors above
PASS_MSG  := PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_FLAGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
